// ==== verilog/host_link_pkg.sv ====
// widths and NI register map shared by RTL and bench; RAM_AW + SIZE_SHIFT must fit in DATA_W
package host_link_pkg;

    // wishbone bus widths
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;
    localparam int TAG_W  = 3;   // master always drives tag zero

    // NI register byte offsets from the NI base
    localparam int unsigned NI_WR_OFS = 4;  // write-pointer register
    localparam int unsigned NI_ST_OFS = 8;  // status register

    // bit index of done in the NI status word
    localparam int NI_DONE_BIT = 0;

    // packet size sits above the NI pointer field in the write word
    localparam int SIZE_SHIFT = 19;

endpackage

// ==== verilog/host_cmd_capture.sv ====
// start_src_i may be asynchronous; pck_size_i must stay stable until two cycles after start falls
`timescale 1ns/1ps

module host_cmd_capture #(
    parameter int RAM_AW = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_src_i,
    input  logic [RAM_AW-1:0] pck_size_i,
    output logic              start_pulse_o,
    output logic [RAM_AW-1:0] launch_size_o,
    output logic              irq_o,
    output logic              led_o
);

    logic              sync1_q;
    logic              sync2_q;
    logic              dly_q;
    logic              fall;
    logic [RAM_AW-1:0] size_stage_q;

    assign fall  = dly_q & ~sync2_q;  // synchronized level went low
    assign irq_o = start_pulse_o;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync1_q       <= 1'b0;
            sync2_q       <= 1'b0;
            dly_q         <= 1'b0;
            start_pulse_o <= 1'b0;
            led_o         <= 1'b0;
        end else begin
            sync1_q       <= start_src_i;
            sync2_q       <= sync1_q;
            dly_q         <= sync2_q;
            start_pulse_o <= fall;
            if (start_pulse_o) begin
                led_o <= 1'b1;  // sticky until reset
            end
        end
    end

    // size tracks the host while start is still seen high, so the value
    // is taken before the host is free to change it
    always_ff @(posedge clk) begin
        if (sync1_q) begin
            size_stage_q <= pck_size_i;
        end
        if (fall) begin
            launch_size_o <= size_stage_q;  // valid with the pulse
        end
    end

endmodule

// ==== verilog/ni_launch_ctrl.sv ====
// one launch at a time; the NI must answer every strobe, and an err on a poll never counts as done
`timescale 1ns/1ps

module ni_launch_ctrl
    import host_link_pkg::*;
#(
    parameter int          RAM_AW       = 8,
    parameter int          M_AW         = 13,
    parameter int unsigned NI_BASE_ADDR = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_pulse_i,
    input  logic [RAM_AW-1:0] launch_size_i,
    output logic [DATA_W-1:0] m_dat_o,
    output logic [SEL_W-1:0]  m_sel_o,
    output logic [M_AW-1:0]   m_addr_o,
    output logic [TAG_W-1:0]  m_tag_o,
    output logic              m_stb_o,
    output logic              m_cyc_o,
    output logic              m_we_o,
    input  logic [DATA_W-1:0] m_dat_i,
    input  logic              m_ack_i,
    input  logic              m_err_i,
    output logic              ni_busy_o,
    output logic [7:0]        ni_err_o
);

    localparam logic [M_AW-1:0] NI_WR_ADDR = M_AW'(NI_BASE_ADDR + NI_WR_OFS);
    localparam logic [M_AW-1:0] NI_ST_ADDR = M_AW'(NI_BASE_ADDR + NI_ST_OFS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_NI,
        ST_WAIT_1,
        ST_POLL
    } state_t;

    state_t            state_q;
    state_t            state_d;
    logic              bus_done;
    logic              ni_done;
    logic [DATA_W-1:0] wr_word_q;

    if (RAM_AW + SIZE_SHIFT > DATA_W) begin : g_size_check
        $error("packet size field does not fit in the NI write word");
    end

    assign bus_done = m_ack_i | m_err_i;              // err ends the cycle like ack
    assign ni_done  = m_ack_i & m_dat_i[NI_DONE_BIT];

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:     if (start_pulse_i) state_d = ST_WRITE_NI;
            ST_WRITE_NI: if (bus_done) state_d = ST_WAIT_1;
            ST_WAIT_1:   state_d = ST_POLL;        // one cycle with stb low
            ST_POLL:     if (ni_done) state_d = ST_IDLE;
            default:     state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q  <= ST_IDLE;
            ni_err_o <= 8'd0;
        end else begin
            state_q <= state_d;
            if (m_stb_o && m_err_i && ni_err_o != 8'hff) begin
                ni_err_o <= ni_err_o + 8'd1;  // saturates
            end
        end
    end

    // word frozen at launch so a late start cannot disturb a held strobe
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && start_pulse_i) begin
            wr_word_q <= DATA_W'(launch_size_i) << SIZE_SHIFT;
        end
    end

    assign m_stb_o   = (state_q == ST_WRITE_NI) || (state_q == ST_POLL);
    assign m_cyc_o   = (state_q != ST_IDLE) && (state_q != ST_WAIT_1);
    assign m_we_o    = (state_q == ST_WRITE_NI);
    assign m_addr_o  = (state_q == ST_POLL) ? NI_ST_ADDR : NI_WR_ADDR;
    assign m_dat_o   = wr_word_q;
    assign m_sel_o   = '1;  // full word
    assign m_tag_o   = '0;  // classic cycles only
    assign ni_busy_o = (state_q != ST_IDLE);

    // a strobe without response keeps its request unchanged
    a_hold_until_ack: assert property (
        @(posedge clk) disable iff (reset)
        m_stb_o && !m_ack_i && !m_err_i |=>
            m_stb_o && $stable(m_addr_o) && $stable(m_dat_o) && $stable(m_we_o)
    ) else $error("master changed a held request before ack");

    a_stb_in_cyc: assert property (
        @(posedge clk) disable iff (reset)
        m_stb_o |-> m_cyc_o
    ) else $error("stb raised outside cyc");

endmodule

// ==== verilog/host_packet_ram.sv ====
// slave serves single full-word classic reads only; write strobes get err and never touch the RAM
`timescale 1ns/1ps

module host_packet_ram
    import host_link_pkg::*;
#(
    parameter int RAM_AW = 8
) (
    input  logic              clk,
    input  logic              reset,
    // host fill port
    input  logic              host_wr_i,
    input  logic [RAM_AW-1:0] host_addr_i,
    input  logic [DATA_W-1:0] host_data_i,
    // wishbone slave, word addressed
    input  logic [RAM_AW-1:0] s_addr_i,
    input  logic [DATA_W-1:0] s_dat_i,
    input  logic [SEL_W-1:0]  s_sel_i,
    input  logic [TAG_W-1:0]  s_tag_i,
    input  logic              s_stb_i,
    input  logic              s_cyc_i,
    input  logic              s_we_i,
    output logic [DATA_W-1:0] s_dat_o,
    output logic              s_ack_o,
    output logic              s_err_o
);

    localparam int DEPTH = 2 ** RAM_AW;

    logic [DATA_W-1:0] mem [DEPTH];
    logic              rd_req;

    // no new request in the ack cycle, so ack drops for one cycle in between
    assign rd_req   = s_stb_i & s_cyc_i & ~s_we_i & ~s_ack_o;
    assign s_err_o  = s_stb_i & s_cyc_i & s_we_i;   // refused in the same cycle

    always_ff @(posedge clk) begin
        if (host_wr_i) begin
            mem[host_addr_i] <= host_data_i;
        end
        if (rd_req) begin
            s_dat_o <= mem[s_addr_i];  // old word on a same-cycle host write
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_ack_o <= 1'b0;
        end else begin
            s_ack_o <= rd_req;
        end
    end

    a_ack_err_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(s_ack_o && s_err_o)
    ) else $error("ack and err raised together");

    // the NI side must issue plain full-word reads
    a_classic_read: assert property (
        @(posedge clk) disable iff (reset)
        s_stb_i && s_cyc_i && !s_we_i |-> (s_sel_i == '1) && (s_tag_i == '0)
    ) else $error("unsupported read cycle on packet buffer");

endmodule

// ==== verilog/host_link_top.sv ====
// RAM_AW from 4 to 12; the NI sits on the m_ ports and reads packets through the s_ ports
`timescale 1ns/1ps

module host_link_top
    import host_link_pkg::*;
#(
    parameter int          RAM_AW       = 8,
    parameter int          M_AW         = 13,
    parameter int unsigned NI_BASE_ADDR = 0
) (
    input  logic              clk,
    input  logic              reset,
    // host command
    input  logic              start_src_i,
    input  logic [RAM_AW-1:0] pck_size_i,
    output logic              irq_o,
    output logic              led_o,
    // host fill port
    input  logic              host_wr_i,
    input  logic [RAM_AW-1:0] host_addr_i,
    input  logic [DATA_W-1:0] host_data_i,
    // packet buffer slave
    input  logic [RAM_AW-1:0] s_addr_i,
    input  logic [DATA_W-1:0] s_dat_i,
    input  logic [SEL_W-1:0]  s_sel_i,
    input  logic [TAG_W-1:0]  s_tag_i,
    input  logic              s_stb_i,
    input  logic              s_cyc_i,
    input  logic              s_we_i,
    output logic [DATA_W-1:0] s_dat_o,
    output logic              s_ack_o,
    output logic              s_err_o,
    // NI register master
    output logic [DATA_W-1:0] m_dat_o,
    output logic [SEL_W-1:0]  m_sel_o,
    output logic [M_AW-1:0]   m_addr_o,
    output logic [TAG_W-1:0]  m_tag_o,
    output logic              m_stb_o,
    output logic              m_cyc_o,
    output logic              m_we_o,
    input  logic [DATA_W-1:0] m_dat_i,
    input  logic              m_ack_i,
    input  logic              m_err_i,
    output logic              ni_busy_o,
    output logic [7:0]        ni_err_o
);

    logic              start_pulse;
    logic [RAM_AW-1:0] launch_size;

    host_cmd_capture #(
        .RAM_AW (RAM_AW)
    ) u_host_cmd_capture (
        .clk           (clk),
        .reset         (reset),
        .start_src_i   (start_src_i),
        .pck_size_i    (pck_size_i),
        .start_pulse_o (start_pulse),
        .launch_size_o (launch_size),
        .irq_o         (irq_o),
        .led_o         (led_o)
    );

    ni_launch_ctrl #(
        .RAM_AW       (RAM_AW),
        .M_AW         (M_AW),
        .NI_BASE_ADDR (NI_BASE_ADDR)
    ) u_ni_launch_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start_pulse_i (start_pulse),
        .launch_size_i (launch_size),
        .m_dat_o       (m_dat_o),
        .m_sel_o       (m_sel_o),
        .m_addr_o      (m_addr_o),
        .m_tag_o       (m_tag_o),
        .m_stb_o       (m_stb_o),
        .m_cyc_o       (m_cyc_o),
        .m_we_o        (m_we_o),
        .m_dat_i       (m_dat_i),
        .m_ack_i       (m_ack_i),
        .m_err_i       (m_err_i),
        .ni_busy_o     (ni_busy_o),
        .ni_err_o      (ni_err_o)
    );

    host_packet_ram #(
        .RAM_AW (RAM_AW)
    ) u_host_packet_ram (
        .clk         (clk),
        .reset       (reset),
        .host_wr_i   (host_wr_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i),
        .s_addr_i    (s_addr_i),
        .s_dat_i     (s_dat_i),
        .s_sel_i     (s_sel_i),
        .s_tag_i     (s_tag_i),
        .s_stb_i     (s_stb_i),
        .s_cyc_i     (s_cyc_i),
        .s_we_i      (s_we_i),
        .s_dat_o     (s_dat_o),
        .s_ack_o     (s_ack_o),
        .s_err_o     (s_err_o)
    );

endmodule

// ==== bench/ni_reg_model.sv ====
// NI register stand-in that acks every strobe and never raises err; wait states and busy polls come from the bench
`timescale 1ns/1ps

module ni_reg_model
    import host_link_pkg::*;
#(
    parameter int          M_AW         = 13,
    parameter int unsigned NI_BASE_ADDR = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [M_AW-1:0]   wb_addr_i,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic              wb_stb_i,
    input  logic              wb_cyc_i,
    input  logic              wb_we_i,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack_o,
    output logic              wb_err_o,
    input  logic [1:0]        wait_i,        // wait states for a strobe starting now
    input  logic [2:0]        busy_polls_i,  // busy reads after each write
    output logic [15:0]       wr_cnt_o,
    output logic [15:0]       rd_cnt_o,
    output logic [7:0]        hold_err_o
);

    localparam logic [M_AW-1:0] ST_ADDR = M_AW'(NI_BASE_ADDR + NI_ST_OFS);

    logic [1:0]        cnt_q;
    logic [1:0]        wait_q;
    logic [1:0]        lim;
    logic [2:0]        polls_left_q;
    logic              st_done;
    logic [M_AW-1:0]   addr_q;
    logic [DATA_W-1:0] dat_q;
    logic              we_q;

    assign lim      = (cnt_q == 2'd0) ? wait_i : wait_q;
    assign st_done  = (wb_addr_i == ST_ADDR) && (polls_left_q == 3'd0);
    assign wb_err_o = 1'b0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack_o     <= 1'b0;
            wb_dat_o     <= '0;
            cnt_q        <= 2'd0;
            wait_q       <= 2'd0;
            polls_left_q <= 3'd0;
            wr_cnt_o     <= 16'd0;
            rd_cnt_o     <= 16'd0;
            hold_err_o   <= 8'd0;
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0;  // access over, a held stb is the next one
            cnt_q    <= 2'd0;
        end else if (wb_stb_i && wb_cyc_i) begin
            if (cnt_q == 2'd0) begin
                addr_q <= wb_addr_i;
                dat_q  <= wb_dat_i;
                we_q   <= wb_we_i;
                wait_q <= wait_i;
            end else if (wb_addr_i != addr_q || wb_dat_i != dat_q || wb_we_i != we_q) begin
                hold_err_o <= hold_err_o + 8'd1;
                $display("model: held request changed before ack at %0t", $time);
            end
            if (cnt_q == lim) begin
                wb_ack_o <= 1'b1;
                if (wb_we_i) begin
                    wr_cnt_o     <= wr_cnt_o + 16'd1;
                    polls_left_q <= busy_polls_i;
                    $display("model: write 0x%08h at 0x%0h, %0t", wb_dat_i, wb_addr_i, $time);
                end else begin
                    rd_cnt_o <= rd_cnt_o + 16'd1;
                    wb_dat_o <= DATA_W'(st_done) << NI_DONE_BIT;
                    if (polls_left_q != 3'd0) begin
                        polls_left_q <= polls_left_q - 3'd1;
                    end
                    $display("model: read at 0x%0h done %0b, %0t", wb_addr_i, st_done, $time);
                end
            end else begin
                cnt_q <= cnt_q + 2'd1;
            end
        end
    end

endmodule

// ==== bench/host_link_tb.sv ====
// parameters below must match the DUT defaults; the NI model answers every strobe with ack
`timescale 1ns/1ps

module host_link_tb
    import host_link_pkg::*;
();

    localparam int          RAM_AW       = 8;
    localparam int          M_AW         = 13;
    localparam int unsigned NI_BASE_ADDR = 0;
    localparam int          DEPTH        = 2 ** RAM_AW;
    localparam int          CLK_PERIOD   = 20;
    localparam int          N_BAD        = 8;
    localparam int          N_LAUNCH     = 10;
    localparam int          OP_CYC       = 64;  // worst case cycles of any one operation
    localparam int          N_OPS        = 2 * DEPTH + 2 * N_BAD + N_LAUNCH + 1;
    localparam int          WATCHDOG_NS  = 2 * N_OPS * OP_CYC * CLK_PERIOD;

    logic              clk;
    logic              reset;
    logic              start_src_i;
    logic [RAM_AW-1:0] pck_size_i;
    logic              irq_o;
    logic              led_o;
    logic              host_wr_i;
    logic [RAM_AW-1:0] host_addr_i;
    logic [DATA_W-1:0] host_data_i;
    logic [RAM_AW-1:0] s_addr_i;
    logic [DATA_W-1:0] s_dat_i;
    logic [SEL_W-1:0]  s_sel_i;
    logic [TAG_W-1:0]  s_tag_i;
    logic              s_stb_i;
    logic              s_cyc_i;
    logic              s_we_i;
    logic [DATA_W-1:0] s_dat_o;
    logic              s_ack_o;
    logic              s_err_o;
    logic [DATA_W-1:0] m_dat_o;
    logic [SEL_W-1:0]  m_sel_o;
    logic [M_AW-1:0]   m_addr_o;
    logic [TAG_W-1:0]  m_tag_o;
    logic              m_stb_o;
    logic              m_cyc_o;
    logic              m_we_o;
    logic [DATA_W-1:0] m_dat_i;
    logic              m_ack_i;
    logic              m_err_i;
    logic              ni_busy_o;
    logic [7:0]        ni_err_o;
    logic [1:0]        wait_sel;
    logic [2:0]        busy_polls;
    logic [15:0]       wr_cnt;
    logic [15:0]       rd_cnt;
    logic [7:0]        hold_err;

    logic [DATA_W-1:0] shadow [DEPTH];
    logic [RAM_AW-1:0] rd_addr_q [$];  // slave reads waiting for ack
    logic [RAM_AW-1:0] cur_size;
    int                irq_cnt = 0;
    int                err_word = 0;
    int                err_launch = 0;
    int                err_flag = 0;
    int                err_other = 0;

    host_link_top #(
        .RAM_AW       (RAM_AW),
        .M_AW         (M_AW),
        .NI_BASE_ADDR (NI_BASE_ADDR)
    ) u_host_link_top (.*);

    ni_reg_model #(
        .M_AW         (M_AW),
        .NI_BASE_ADDR (NI_BASE_ADDR)
    ) u_ni_reg_model (
        .clk          (clk),
        .reset        (reset),
        .wb_addr_i    (m_addr_o),
        .wb_dat_i     (m_dat_o),
        .wb_stb_i     (m_stb_o),
        .wb_cyc_i     (m_cyc_o),
        .wb_we_i      (m_we_o),
        .wb_dat_o     (m_dat_i),
        .wb_ack_o     (m_ack_i),
        .wb_err_o     (m_err_i),
        .wait_i       (wait_sel),
        .busy_polls_i (busy_polls),
        .wr_cnt_o     (wr_cnt),
        .rd_cnt_o     (rd_cnt),
        .hold_err_o   (hold_err)
    );

    // expected values straight from the register map and the shadow copy
    function automatic logic [DATA_W-1:0] exp_ni_word(input logic [RAM_AW-1:0] size);
        logic [DATA_W-1:0] word;
        word = '0;
        word[SIZE_SHIFT +: RAM_AW] = size;  // size field above the NI pointer
        return word;
    endfunction

    function automatic logic [M_AW-1:0] exp_ni_addr(input int unsigned ofs);
        return M_AW'(NI_BASE_ADDR + ofs);
    endfunction

    function automatic logic [DATA_W-1:0] exp_ram_word(input logic [RAM_AW-1:0] addr);
        return shadow[addr];
    endfunction

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            err_word++;
        end
    endtask

    task automatic check_launch(input logic [M_AW-1:0] got_addr,
                                input logic [M_AW-1:0] exp_addr,
                                input logic [DATA_W-1:0] got_dat,
                                input logic [DATA_W-1:0] exp_dat);
        if (got_addr !== exp_addr || got_dat !== exp_dat) begin
            $display("[ERROR] %0t ns: NI write 0x%08h at 0x%0h expected 0x%08h at 0x%0h",
                     $time, got_dat, got_addr, exp_dat, exp_addr);
            err_launch++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s got %0b expected %0b", $time, what, got, exp);
            err_flag++;
        end
    endtask

    task automatic host_write(input logic [RAM_AW-1:0] addr, input logic [DATA_W-1:0] data);
        host_wr_i   = 1'b1;
        host_addr_i = addr;
        host_data_i = data;
        shadow[addr] = data;
        @(negedge clk);
        host_wr_i = 1'b0;
    endtask

    task automatic slave_read(input logic [RAM_AW-1:0] addr);
        rd_addr_q.push_back(addr);
        s_addr_i = addr;
        s_we_i   = 1'b0;
        s_stb_i  = 1'b1;
        s_cyc_i  = 1'b1;
        @(negedge clk);
        check_flag(s_ack_o, 1'b1, "read ack one cycle after strobe");
        s_stb_i = 1'b0;
        s_cyc_i = 1'b0;
        @(negedge clk);
        check_flag(s_ack_o, 1'b0, "ack low after read");
    endtask

    // inverted data so a leak into the RAM shows on the read back
    task automatic slave_write_refused(input logic [RAM_AW-1:0] addr);
        s_addr_i = addr;
        s_dat_i  = ~shadow[addr];
        s_we_i   = 1'b1;
        s_stb_i  = 1'b1;
        s_cyc_i  = 1'b1;
        #(CLK_PERIOD / 4);
        check_flag(s_err_o, 1'b1, "err on slave write");
        check_flag(s_ack_o, 1'b0, "no ack on slave write");
        @(negedge clk);
        s_stb_i = 1'b0;
        s_cyc_i = 1'b0;
        s_we_i  = 1'b0;
        check_flag(s_ack_o, 1'b0, "no ack after slave write");
    endtask

    task automatic run_launch(input logic [RAM_AW-1:0] size, input int polls, input bit extra);
        int wr0;
        int rd0;
        int irq0;
        int n;
        wr0  = wr_cnt;
        rd0  = rd_cnt;
        irq0 = irq_cnt;
        cur_size    = size;
        pck_size_i  = size;
        busy_polls  = 3'(polls);
        start_src_i = 1'b1;
        repeat (3) @(negedge clk);
        start_src_i = 1'b0;
        n = 0;
        while (!ni_busy_o && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!ni_busy_o) begin
            $display("launch of size %0d never raised busy", size);
            err_other++;
        end
        n = 0;
        while (ni_busy_o && n < OP_CYC) begin
            wait_sel = 2'($urandom_range(3, 0));
            if (extra) begin
                start_src_i = (n == 1);  // short start level while busy
            end
            @(negedge clk);
            n++;
        end
        if (ni_busy_o) begin
            $display("launch of size %0d stayed busy for %0d cycles", size, n);
            err_other++;
        end
        repeat (extra ? 8 : 1) @(negedge clk);
        check_flag(wr_cnt - wr0 == 1, 1'b1, "exactly one NI write per launch");
        check_flag(rd_cnt - rd0 == polls + 1, 1'b1, "status reads up to done");
        check_flag(irq_cnt - irq0 == (extra ? 2 : 1), 1'b1, "irq per start edge");
        check_flag(led_o, 1'b1, "led after launch");
        check_flag(ni_busy_o, 1'b0, "idle after launch");
    endtask

    // compares every acked bus response against the reference functions
    always @(negedge clk) begin : compare_proc
        logic [RAM_AW-1:0] rd_addr;
        if (!reset) begin
            if (s_ack_o) begin
                if (rd_addr_q.size() == 0) begin
                    $display("slave ack with no read outstanding at %0t ns", $time);
                    err_other++;
                end else begin
                    rd_addr = rd_addr_q.pop_front();
                    check_word(s_dat_o, exp_ram_word(rd_addr), "slave read data");
                end
            end
            if (m_stb_o && m_ack_i) begin
                if (m_we_o) begin
                    check_launch(m_addr_o, exp_ni_addr(NI_WR_OFS),
                                 m_dat_o, exp_ni_word(cur_size));
                end else begin
                    check_flag(m_addr_o == exp_ni_addr(NI_ST_OFS), 1'b1, "status read address");
                end
                check_flag(m_sel_o == '1 && m_tag_o == '0, 1'b1, "full word select, tag zero");
            end
            if (irq_o) begin
                irq_cnt++;
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        start_src_i = 1'b0;
        pck_size_i  = '0;
        host_wr_i   = 1'b0;
        host_addr_i = '0;
        host_data_i = '0;
        s_addr_i    = '0;
        s_dat_i     = '0;
        s_sel_i     = '1;
        s_tag_i     = '0;
        s_stb_i     = 1'b0;
        s_cyc_i     = 1'b0;
        s_we_i      = 1'b0;
        wait_sel    = 2'd0;
        busy_polls  = 3'd0;
        cur_size    = '0;
        void'($urandom(5519));
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // quiet after reset, no master cycle without a start
        repeat (10) begin
            check_flag(led_o | irq_o | ni_busy_o, 1'b0, "led, irq, busy after reset");
            check_flag(m_stb_o | m_cyc_o | s_ack_o, 1'b0, "bus idle after reset");
            @(negedge clk);
        end

        for (int i = 0; i < DEPTH; i++) begin
            host_write(RAM_AW'(i), $urandom());
        end
        for (int i = 0; i < DEPTH; i++) begin
            slave_read(RAM_AW'(i));
        end
        for (int i = 0; i < N_BAD; i++) begin
            automatic logic [RAM_AW-1:0] a = RAM_AW'($urandom());
            slave_write_refused(a);
            slave_read(a);
        end
        check_flag(wr_cnt == 0 && rd_cnt == 0, 1'b1, "no NI access before first start");
        check_flag(led_o, 1'b0, "led low before first launch");

        for (int i = 0; i < N_LAUNCH; i++) begin
            run_launch(RAM_AW'($urandom()), int'($urandom_range(4, 0)), 1'b0);
        end
        run_launch(RAM_AW'($urandom()), 4, 1'b1);  // second start lands while busy

        check_flag(hold_err == 8'd0, 1'b1, "held requests stable in NI model");
        check_flag(ni_err_o == 8'd0, 1'b1, "no NI err counted");

        $display("errors: word %0d, launch %0d, flag %0d, other %0d",
                 err_word, err_launch, err_flag, err_other);
        if (err_word + err_launch + err_flag + err_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/host_link_pkg.sv
verilog/host_cmd_capture.sv
verilog/ni_launch_ctrl.sv
verilog/host_packet_ram.sv
verilog/host_link_top.sv
bench/ni_reg_model.sv
bench/host_link_tb.sv

// ==== Bender.yml ====
package:
  name: host_link

dependencies: {}

sources:
  # package first, then the pipeline stages and the top level
  - verilog/host_link_pkg.sv
  - verilog/host_cmd_capture.sv
  - verilog/ni_launch_ctrl.sv
  - verilog/host_packet_ram.sv
  - verilog/host_link_top.sv

  # testbench with the NI register model
  - target: test
    files:
      - bench/ni_reg_model.sv
      - bench/host_link_tb.sv
